// File: mc_defines.svh
//////////////////////////////////////////////////
// Controller sizing and refresh timing in cycles
// MC_REFRESH_PERIOD must exceed MC_REFRESH_CYCLES
//////////////////////////////////////////////////
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

//////////////////////////////////////////////////
// Bank organisation
//////////////////////////////////////////////////
`define MC_NUM_BANKS 4       // Banks on the shared bus
`define MC_BANK_BITS 2       // Bank index width

//////////////////////////////////////////////////
// Address fields
//////////////////////////////////////////////////
// Column addresses are zero-extended onto the row-wide bus
`define MC_ROW_BITS 12
`define MC_COL_BITS 10

//////////////////////////////////////////////////
// Refresh
//////////////////////////////////////////////////
`define MC_REFRESH_PERIOD 400  // Cycles from refresh done to next due
`define MC_REFRESH_CYCLES 12   // Bus held idle after REF

`endif

// File: mc_pkg.sv
//////////////////////////////////////////////////
// Shared state and bus command encodings
// Command codes are what appears on dram_cmd
//////////////////////////////////////////////////
package mc_pkg;

  //////////////////////////////////////////////////
  // Per-bank sequencing states
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    B_IDLE         = 4'd0,  // Row closed, may accept
    B_ACTIVE       = 4'd1,  // Waiting to issue ACT
    B_READ         = 4'd2,
    B_WRITE        = 4'd3,
    B_READA        = 4'd4,  // Read, row closes after
    B_WRITEA       = 4'd5,  // Write, row closes after
    B_ACT_STANDBY  = 4'd6,  // Row open, may accept
    B_PRE          = 4'd7,  // Waiting to issue PRE
    B_REFRESH_WAIT = 4'd8   // Parked until refresh ends
  } bank_state_t;

  //////////////////////////////////////////////////
  // DRAM command bus
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    CMD_NOP = 3'd0,
    CMD_ACT = 3'd1,  // Address is the row
    CMD_RD  = 3'd2,  // Address is the column
    CMD_WR  = 3'd3,
    CMD_RDA = 3'd4,
    CMD_WRA = 3'd5,
    CMD_PRE = 3'd6,  // Single bank, address zero
    CMD_REF = 3'd7   // All banks, bank zero
  } dram_cmd_t;

  // Both enums are used by the testbench as well

endpackage

// File: bank_fsm.sv
//////////////////////////////////////////////////
// One bank, open-page policy, one request at a time
// Steps only on grant, waits forever without one
//////////////////////////////////////////////////
`include "mc_defines.svh"

module bank_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  logic                    req_rw,       // 1 means read
  input  logic                    req_ap,
  input  logic [`MC_ROW_BITS-1:0] req_row,
  input  logic [`MC_COL_BITS-1:0] req_col,
  input  logic                    grant,
  input  logic                    refresh_due,
  input  logic                    refresh_done,
  output logic                    busy,
  output logic                    issue_req,
  output mc_pkg::dram_cmd_t       issue_cmd,
  output logic [`MC_ROW_BITS-1:0] issue_addr,
  output logic                    refresh_ready
);

  import mc_pkg::*;

  localparam int ROW_W = `MC_ROW_BITS;

  bank_state_t             state;
  bank_state_t             state_next;
  logic                    accept;
  logic                    row_hit;
  logic                    pre_ref;    // Current PRE is for refresh
  logic                    rw_q;
  logic                    ap_q;
  logic [`MC_ROW_BITS-1:0] row_q;
  logic [`MC_COL_BITS-1:0] col_q;
  logic [`MC_ROW_BITS-1:0] open_row;

  // Access state for a read/write with or without auto-precharge
  function automatic bank_state_t access_state(input logic rw, input logic ap);
    if (ap)
      return rw ? B_READA : B_WRITEA;
    return rw ? B_READ : B_WRITE;
  endfunction

  assign busy          = refresh_due || !(state inside {B_IDLE, B_ACT_STANDBY});
  assign accept        = req_valid && !busy;
  assign row_hit       = req_row == open_row;  // Only meaningful in standby
  assign refresh_ready = state == B_REFRESH_WAIT;
  assign issue_req     = issue_cmd != CMD_NOP;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      B_IDLE: begin
        if (refresh_due)
          state_next = B_REFRESH_WAIT;  // Nothing open, park now
        else if (accept)
          state_next = B_ACTIVE;
      end
      B_ACT_STANDBY: begin
        if (refresh_due)
          state_next = B_PRE;           // Close row before REF
        else if (accept)
          state_next = row_hit ? access_state(req_rw, req_ap) : B_PRE;
      end
      B_ACTIVE:          if (grant) state_next = access_state(rw_q, ap_q);
      B_READ, B_WRITE:   if (grant) state_next = B_ACT_STANDBY;
      B_READA, B_WRITEA: if (grant) state_next = B_IDLE;
      B_PRE:             if (grant) state_next = pre_ref ? B_REFRESH_WAIT : B_ACTIVE;
      B_REFRESH_WAIT:    if (refresh_done) state_next = B_IDLE;
      default:           state_next = B_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= B_IDLE;
      pre_ref <= 1'b0;
    end else begin
      state <= state_next;
      if (state == B_ACT_STANDBY)
        pre_ref <= refresh_due;  // Conflict PRE only when refresh is low
    end
  end

  // Request fields and open row
  always_ff @(posedge clk) begin
    if (accept) begin
      rw_q  <= req_rw;
      ap_q  <= req_ap;
      row_q <= req_row;
      col_q <= req_col;
    end
    if (state == B_ACTIVE && grant)
      open_row <= row_q;
  end

  //////////////////////////////////////////////////
  // Command to the arbiter
  //////////////////////////////////////////////////
  always_comb begin
    issue_cmd  = CMD_NOP;
    issue_addr = '0;
    case (state)
      B_ACTIVE: begin
        issue_cmd  = CMD_ACT;
        issue_addr = row_q;
      end
      B_READ: begin
        issue_cmd  = CMD_RD;
        issue_addr = ROW_W'(col_q);
      end
      B_WRITE: begin
        issue_cmd  = CMD_WR;
        issue_addr = ROW_W'(col_q);
      end
      B_READA: begin
        issue_cmd  = CMD_RDA;
        issue_addr = ROW_W'(col_q);
      end
      B_WRITEA: begin
        issue_cmd  = CMD_WRA;
        issue_addr = ROW_W'(col_q);
      end
      B_PRE:   issue_cmd = CMD_PRE;  // Address stays zero
      default: issue_cmd = CMD_NOP;
    endcase
  end

  // Resting states never hold the bus
  a_no_issue_at_rest: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {B_IDLE, B_ACT_STANDBY} |-> !issue_req);

  // An accepted request blocks the next one and goes straight to the bus
  a_accept_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> busy && issue_req);

endmodule

// File: cmd_arbiter.sv
//////////////////////////////////////////////////
// Round-robin over banks plus refresh, top index
// Winner shows on the bus one cycle after grant
//////////////////////////////////////////////////
`include "mc_defines.svh"

module cmd_arbiter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`MC_NUM_BANKS:0]   req,
  input  mc_pkg::dram_cmd_t        cmd_in [`MC_NUM_BANKS+1],
  input  logic [`MC_ROW_BITS-1:0]  addr_in [`MC_NUM_BANKS+1],
  input  logic                     block,
  output logic [`MC_NUM_BANKS:0]   grant,
  output mc_pkg::dram_cmd_t        dram_cmd,
  output logic [`MC_BANK_BITS-1:0] dram_bank,
  output logic [`MC_ROW_BITS-1:0]  dram_addr
);

  import mc_pkg::*;

  localparam int NREQ  = `MC_NUM_BANKS + 1;
  localparam int IDX_W = $clog2(NREQ);

  logic [IDX_W-1:0] ptr;      // Highest priority this cycle
  logic [IDX_W-1:0] win_idx;
  logic             found;
  int               cand;

  always_comb begin
    grant   = '0;
    win_idx = '0;
    found   = 1'b0;
    cand    = 0;
    for (int i = 0; i < NREQ; i++) begin
      cand = (int'(ptr) + i) % NREQ;
      if (!found && !block && req[cand]) begin
        found       = 1'b1;
        win_idx     = IDX_W'(cand);
        grant[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr       <= '0;
      dram_cmd  <= CMD_NOP;
      dram_bank <= '0;
      dram_addr <= '0;
    end else if (found) begin
      ptr       <= (win_idx == IDX_W'(NREQ - 1)) ? '0 : win_idx + 1'b1;
      dram_cmd  <= cmd_in[win_idx];
      dram_bank <= (win_idx == IDX_W'(NREQ - 1)) ? '0 : win_idx[`MC_BANK_BITS-1:0];
      dram_addr <= addr_in[win_idx];
    end else begin
      dram_cmd  <= CMD_NOP;
      dram_bank <= '0;
      dram_addr <= '0;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant));
  a_grant_to_req: assert property (@(posedge clk) disable iff (!rst_n) (grant & ~req) == '0);

endmodule

// File: refresh_ctrl.sv
//////////////////////////////////////////////////
// Periodic all-bank refresh, interval from last done
// REF is requested only once every bank is parked
//////////////////////////////////////////////////
`include "mc_defines.svh"

module refresh_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`MC_NUM_BANKS-1:0] refresh_ready,
  input  logic                     grant,          // REF slot of the arbiter
  output logic                     refresh_due,
  output logic                     ref_issue_req,
  output logic                     block,
  output logic                     refresh_done
);

  localparam int CNT_W = $clog2(`MC_REFRESH_PERIOD);
  localparam logic [CNT_W-1:0] PERIOD_LAST  = CNT_W'(`MC_REFRESH_PERIOD - 1);
  localparam logic [CNT_W-1:0] RECOVER_LAST = CNT_W'(`MC_REFRESH_CYCLES - 1);

  typedef enum logic [1:0] {R_COUNT, R_DUE, R_RECOVER} ref_state_t;

  ref_state_t       state;
  logic [CNT_W-1:0] cnt;  // Interval up, recovery down

  assign refresh_due   = state != R_COUNT;  // Held until banks are released
  assign ref_issue_req = (state == R_DUE) && (&refresh_ready);
  assign block         = state == R_RECOVER;
  assign refresh_done  = (state == R_RECOVER) && (cnt == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= R_COUNT;
      cnt   <= '0;
    end else begin
      case (state)
        R_COUNT: begin
          if (cnt == PERIOD_LAST) begin
            state <= R_DUE;
            cnt   <= '0;
          end else
            cnt <= cnt + 1'b1;
        end
        R_DUE: begin
          if (ref_issue_req && grant) begin
            state <= R_RECOVER;     // REF reaches the bus next cycle
            cnt   <= RECOVER_LAST;
          end
        end
        R_RECOVER: begin
          if (cnt == '0)
            state <= R_COUNT;       // Interval restarts from zero
          else
            cnt <= cnt - 1'b1;
        end
        default: state <= R_COUNT;
      endcase
    end
  end

endmodule

// File: dram_ctrl_top.sv
//////////////////////////////////////////////////
// Host valid/ready in, DRAM command bus out
// req_ready follows the bank named by req_bank
//////////////////////////////////////////////////
`include "mc_defines.svh"

module dram_ctrl_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid,
  input  logic                     req_rw,
  input  logic                     req_ap,
  input  logic [`MC_BANK_BITS-1:0] req_bank,
  input  logic [`MC_ROW_BITS-1:0]  req_row,
  input  logic [`MC_COL_BITS-1:0]  req_col,
  output logic                     req_ready,
  output mc_pkg::dram_cmd_t        dram_cmd,
  output logic [`MC_BANK_BITS-1:0] dram_bank,
  output logic [`MC_ROW_BITS-1:0]  dram_addr
);

  import mc_pkg::*;

  localparam int NB = `MC_NUM_BANKS;

  wire [NB-1:0]            bank_valid;
  wire [NB-1:0]            bank_busy;
  wire [NB-1:0]            bank_ref_ready;
  wire [NB:0]              arb_req;     // Top bit is refresh
  wire [NB:0]              arb_grant;
  wire dram_cmd_t          arb_cmd  [NB+1];
  wire [`MC_ROW_BITS-1:0]  arb_addr [NB+1];
  wire                     refresh_due;
  wire                     refresh_done;
  wire                     ref_block;

  assign req_ready = !bank_busy[req_bank];

  //////////////////////////////////////////////////
  // Bank peers
  //////////////////////////////////////////////////
  for (genvar g = 0; g < NB; g++) begin : gen_bank
    assign bank_valid[g] = req_valid && (req_bank == `MC_BANK_BITS'(g));

    bank_fsm bank_fsm_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid     (bank_valid[g]),
      .req_rw        (req_rw),
      .req_ap        (req_ap),
      .req_row       (req_row),
      .req_col       (req_col),
      .grant         (arb_grant[g]),
      .refresh_due   (refresh_due),
      .refresh_done  (refresh_done),
      .busy          (bank_busy[g]),
      .issue_req     (arb_req[g]),
      .issue_cmd     (arb_cmd[g]),
      .issue_addr    (arb_addr[g]),
      .refresh_ready (bank_ref_ready[g])
    );
  end

  // Refresh slot carries a fixed REF
  assign arb_cmd[NB]  = CMD_REF;
  assign arb_addr[NB] = '0;

  refresh_ctrl refresh_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .refresh_ready (bank_ref_ready),
    .grant         (arb_grant[NB]),
    .refresh_due   (refresh_due),
    .ref_issue_req (arb_req[NB]),
    .block         (ref_block),
    .refresh_done  (refresh_done)
  );

  cmd_arbiter cmd_arbiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (arb_req),
    .cmd_in    (arb_cmd),
    .addr_in   (arb_addr),
    .block     (ref_block),
    .grant     (arb_grant),
    .dram_cmd  (dram_cmd),
    .dram_bank (dram_bank),
    .dram_addr (dram_addr)
  );

endmodule

// File: tb_dram_ctrl.sv
//////////////////////////////////////////////////
// Per-bank command order is checked, bank interleave is free
// Traffic must finish well inside one refresh period
//////////////////////////////////////////////////
`include "mc_defines.svh"

module tb_dram_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  import mc_pkg::*;

  localparam int NB       = `MC_NUM_BANKS;
  localparam int WAIT_MAX = 200;  // Cycles allowed for ready or drain

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     req_valid;
  logic                     req_rw;
  logic                     req_ap;
  logic [`MC_BANK_BITS-1:0] req_bank;
  logic [`MC_ROW_BITS-1:0]  req_row;
  logic [`MC_COL_BITS-1:0]  req_col;
  logic                     req_ready;
  dram_cmd_t                dram_cmd;
  logic [`MC_BANK_BITS-1:0] dram_bank;
  logic [`MC_ROW_BITS-1:0]  dram_addr;

  // Expected bus traffic and open-row model
  dram_cmd_t               exp_cmd  [NB][$];
  logic [`MC_ROW_BITS-1:0] exp_addr [NB][$];
  logic                    row_open [NB];
  logic [`MC_ROW_BITS-1:0] open_row [NB];
  logic                    ref_expected;
  int                      ref_count;
  int                      nop_left;    // Recovery cycles still to see
  int                      mismatches;
  int                      failures;

  dram_ctrl_top dram_ctrl_top_inst (.*);

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_cmd(input dram_cmd_t exp, input dram_cmd_t got);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch dram_cmd: expected %h, got %h", exp, got);
    end
  endtask

  task automatic check_addr(input logic [`MC_ROW_BITS-1:0] exp,
                            input logic [`MC_ROW_BITS-1:0] got);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch dram_addr: expected %h, got %h", exp, got);
    end
  endtask

  task automatic check_bank(input logic [`MC_BANK_BITS-1:0] exp,
                            input logic [`MC_BANK_BITS-1:0] got);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch dram_bank: expected %h, got %h", exp, got);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic void push_exp(input int b, input dram_cmd_t c,
                                   input logic [`MC_ROW_BITS-1:0] a);
    exp_cmd[b].push_back(c);
    exp_addr[b].push_back(a);
  endfunction

  // Command list for one request, open-page policy
  function automatic void predict_cmds(input int b, input logic rw, input logic ap,
                                       input logic [`MC_ROW_BITS-1:0] row,
                                       input logic [`MC_COL_BITS-1:0] col);
    dram_cmd_t acc;
    if (ap)
      acc = rw ? CMD_RDA : CMD_WRA;
    else
      acc = rw ? CMD_RD : CMD_WR;
    if (row_open[b] && open_row[b] != row)
      push_exp(b, CMD_PRE, '0);          // Row conflict
    if (!row_open[b] || open_row[b] != row)
      push_exp(b, CMD_ACT, row);
    push_exp(b, acc, `MC_ROW_BITS'(col));
    row_open[b] = !ap;
    open_row[b] = row;
  endfunction

  function automatic void predict_refresh();
    for (int b = 0; b < NB; b++) begin
      if (row_open[b])
        push_exp(b, CMD_PRE, '0);
      row_open[b] = 1'b0;
    end
    ref_expected = 1'b1;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int b = 0; b < NB; b++)
      n += exp_cmd[b].size();
    return n;
  endfunction

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////
  // Called on a falling edge, returns on a falling edge
  task automatic send_req(input int b, input logic rw, input logic ap,
                          input logic [`MC_ROW_BITS-1:0] row,
                          input logic [`MC_COL_BITS-1:0] col);
    int cycles;
    cycles    = 0;
    req_valid = 1'b1;
    req_bank  = `MC_BANK_BITS'(b);
    req_rw    = rw;
    req_ap    = ap;
    req_row   = row;
    req_col   = col;
    #1;
    while (!req_ready && cycles < WAIT_MAX) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (req_ready)
      predict_cmds(b, rw, ap, row, col);  // Transfers on the coming rising edge
    else begin
      failures++;
      $display("ERROR: timeout waiting for req_ready on bank %0d", b);
    end
    @(negedge clk);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles    = 0;
    req_valid = 1'b0;
    while (pending() != 0 && cycles < WAIT_MAX) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    for (int b = 0; b < NB; b++) begin
      if (exp_cmd[b].size() != 0) begin
        failures++;
        $display("ERROR: bank %0d still expects %0d commands after timeout",
                 b, exp_cmd[b].size());
        exp_cmd[b].delete();
        exp_addr[b].delete();
      end
    end
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Bus monitor, sampled mid-cycle
  //////////////////////////////////////////////////
  always @(negedge clk) begin : compare_bus
    dram_cmd_t               c;
    logic [`MC_ROW_BITS-1:0] a;
    if (rst_n) begin
      if (nop_left > 0) begin
        if (dram_cmd != CMD_NOP) begin
          failures++;
          $display("ERROR: %s issued during refresh recovery", dram_cmd.name());
        end
        nop_left--;
      end else if (dram_cmd == CMD_REF) begin
        ref_count++;
        check_addr('0, dram_addr);
        check_bank('0, dram_bank);
        if (!ref_expected) begin
          failures++;
          $display("ERROR: REF issued when no refresh was expected");
        end
        for (int b = 0; b < NB; b++)
          if (exp_cmd[b].size() != 0) begin
            failures++;
            $display("ERROR: REF issued before bank %0d finished its commands", b);
          end
        ref_expected = 1'b0;
        nop_left     = `MC_REFRESH_CYCLES;
      end else if (dram_cmd != CMD_NOP) begin
        if (exp_cmd[dram_bank].size() == 0) begin
          failures++;
          $display("ERROR: %s on bank %0d with nothing expected", dram_cmd.name(), dram_bank);
        end else begin
          c = exp_cmd[dram_bank].pop_front();
          a = exp_addr[dram_bank].pop_front();
          check_cmd(c, dram_cmd);
          check_addr(a, dram_addr);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    int                      b;
    int                      cycles;
    logic [`MC_ROW_BITS-1:0] row;
    void'($urandom(32'h457862f2));
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_rw       = 1'b0;
    req_ap       = 1'b0;
    req_bank     = '0;
    req_row      = '0;
    req_col      = '0;
    ref_expected = 1'b0;
    ref_count    = 0;
    nop_left     = 0;
    mismatches   = 0;
    failures     = 0;
    for (int i = 0; i < NB; i++) begin
      row_open[i] = 1'b0;
      open_row[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_cmd(CMD_NOP, dram_cmd);
    if (!req_ready) begin
      failures++;
      $display("ERROR: req_ready is low after reset");
    end

    // Closed bank, row hit, then row conflict
    send_req(1, 1'b1, 1'b0, 12'h123, 10'h045);
    wait_drain();
    send_req(1, 1'b0, 1'b0, 12'h123, 10'h0a0);
    wait_drain();
    send_req(1, 1'b1, 1'b0, 12'h456, 10'h3ff);
    wait_drain();
    send_req(2, 1'b0, 1'b1, 12'h0ab, 10'h010);  // Auto-precharge
    wait_drain();
    send_req(2, 1'b1, 1'b0, 12'h0ab, 10'h011);  // Same row, still needs ACT
    send_req(0, 1'b0, 1'b0, 12'h7ff, 10'h001);
    wait_drain();

    // Refresh closes banks 0 to 2
    #1;
    predict_refresh();
    cycles = 0;
    while (ref_count == 0 && cycles < `MC_REFRESH_PERIOD + WAIT_MAX) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (ref_count == 0) begin
      failures++;
      $display("ERROR: timeout waiting for refresh");
    end
    @(negedge clk);
    req_valid = 1'b1;
    req_bank  = '0;
    req_rw    = 1'b1;
    req_row   = 12'h7ff;
    req_col   = 10'h002;
    repeat (`MC_REFRESH_CYCLES - 1) begin
      #1;
      if (req_ready) begin
        failures++;
        $display("ERROR: req_ready went high during refresh recovery");
      end
      @(negedge clk);
    end
    send_req(0, 1'b1, 1'b0, 12'h7ff, 10'h002);  // Row hit before, closed now
    wait_drain();

    // Back-to-back random traffic over all banks
    for (int i = 0; i < 24; i++) begin
      b   = $urandom % NB;
      row = 12'(($urandom % 3) * 12'h155);
      send_req(b, 1'($urandom), ($urandom % 5) == 0, row, 10'($urandom));
    end
    wait_drain();
    repeat (10) @(negedge clk);

    $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: list.f
+incdir+.
mc_pkg.sv
bank_fsm.sv
cmd_arbiter.sv
refresh_ctrl.sv
dram_ctrl_top.sv
tb_dram_ctrl.sv
